// ==== valu_settings.svh ====
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

////////////////////////////////////////
// Vector geometry
////////////////////////////////////////

// Full vector word in bits
`define VALU_VLEN 64

// Lanes per element width
`define VALU_LANES8  8
`define VALU_LANES16 4
`define VALU_LANES32 2

////////////////////////////////////////
// Sequential multiplier
////////////////////////////////////////

// Multiplier bits per cycle, one of 1, 2, 4, 8 or 16
`define VALU_MUL_STEP 8

`endif

// ==== valu_pkg.sv ====
`include "valu_settings.svh"

package valu_pkg;

    // Operation codes
    typedef enum logic [4:0] {
        vand    = 5'd0,
        vor     = 5'd1,
        vxor    = 5'd2,
        vadd    = 5'd3,
        vsub    = 5'd4,
        vrsub   = 5'd5,
        vsll    = 5'd6,
        vsrl    = 5'd7,
        vsra    = 5'd8,
        vmin    = 5'd9,
        vminu   = 5'd10,
        vmax    = 5'd11,
        vmaxu   = 5'd12,
        vmul    = 5'd13,
        vmulh   = 5'd14,
        vmulhu  = 5'd15,
        vmulhsu = 5'd16
    } valu_op_e;

    // Element width
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } sew_e;

    // Operand sign mode, su means first operand signed
    typedef enum logic [1:0] {
        mul_uu = 2'b00,
        mul_su = 2'b01,
        mul_ss = 2'b11
    } mul_sign_e;

    // Three lane views of one vector word
    typedef union packed {
        logic [`VALU_LANES8-1:0][7:0]   b;
        logic [`VALU_LANES16-1:0][15:0] h;
        logic [`VALU_LANES32-1:0][31:0] w;
    } vreg_u;

endpackage

// ==== valu_add_sub.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_add_sub
    import valu_pkg::*;
(
    input  valu_op_e op_i,
    input  sew_e     sew_i,
    input  vreg_u    a_i,
    input  vreg_u    b_i,
    output vreg_u    sum_o
);

    logic  is_sub;
    vreg_u first;
    vreg_u second;

    // Reverse subtract swaps the operands
    assign is_sub = (op_i == vsub) || (op_i == vrsub);
    assign first  = (op_i == vrsub) ? b_i : a_i;
    assign second = (op_i == vrsub) ? a_i : b_i;

    // Each lane adds on its own, no carry into the next lane
    always_comb begin
        unique case (sew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    sum_o.b[i] = first.b[i] + (is_sub ? (~second.b[i] + 8'd1) : second.b[i]);
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    sum_o.h[i] = first.h[i] + (is_sub ? (~second.h[i] + 16'd1) : second.h[i]);
                end
            end
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    sum_o.w[i] = first.w[i] + (is_sub ? (~second.w[i] + 32'd1) : second.w[i]);
                end
            end
        endcase
    end

endmodule

// ==== valu_shift.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_shift
    import valu_pkg::*;
(
    input  sew_e  sew_i,
    input  vreg_u a_i,
    input  vreg_u b_i,
    output vreg_u sll_o,
    output vreg_u srl_o,
    output vreg_u sra_o
);

    // Shift amount is the low log2(width) bits of the lane in b_i
    always_comb begin
        unique case (sew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    sll_o.b[i] = a_i.b[i] << b_i.b[i][2:0];
                    srl_o.b[i] = a_i.b[i] >> b_i.b[i][2:0];
                    // Fill from this lane's own sign bit
                    sra_o.b[i] = $signed(a_i.b[i]) >>> b_i.b[i][2:0];
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    sll_o.h[i] = a_i.h[i] << b_i.h[i][3:0];
                    srl_o.h[i] = a_i.h[i] >> b_i.h[i][3:0];
                    sra_o.h[i] = $signed(a_i.h[i]) >>> b_i.h[i][3:0];
                end
            end
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    sll_o.w[i] = a_i.w[i] << b_i.w[i][4:0];
                    srl_o.w[i] = a_i.w[i] >> b_i.w[i][4:0];
                    sra_o.w[i] = $signed(a_i.w[i]) >>> b_i.w[i][4:0];
                end
            end
        endcase
    end

endmodule

// ==== valu_minmax.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_minmax
    import valu_pkg::*;
(
    input  sew_e  sew_i,
    input  vreg_u a_i,
    input  vreg_u b_i,
    output vreg_u min_o,
    output vreg_u minu_o,
    output vreg_u max_o,
    output vreg_u maxu_o
);

    // Greater-than flags, unsigned and signed, per lane
    logic [`VALU_LANES8-1:0]  gt8,  gts8;
    logic [`VALU_LANES16-1:0] gt16, gts16;
    logic [`VALU_LANES32-1:0] gt32, gts32;

    always_comb begin
        for (int i = 0; i < `VALU_LANES8; i++) begin
            gt8[i]  = a_i.b[i] > b_i.b[i];
            gts8[i] = $signed(a_i.b[i]) > $signed(b_i.b[i]);
        end
        for (int i = 0; i < `VALU_LANES16; i++) begin
            gt16[i]  = a_i.h[i] > b_i.h[i];
            gts16[i] = $signed(a_i.h[i]) > $signed(b_i.h[i]);
        end
        for (int i = 0; i < `VALU_LANES32; i++) begin
            gt32[i]  = a_i.w[i] > b_i.w[i];
            gts32[i] = $signed(a_i.w[i]) > $signed(b_i.w[i]);
        end
    end

    // Equal lanes take a_i for min and b_i for max, same value either way
    always_comb begin
        unique case (sew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    minu_o.b[i] = gt8[i]  ? b_i.b[i] : a_i.b[i];
                    min_o.b[i]  = gts8[i] ? b_i.b[i] : a_i.b[i];
                    maxu_o.b[i] = gt8[i]  ? a_i.b[i] : b_i.b[i];
                    max_o.b[i]  = gts8[i] ? a_i.b[i] : b_i.b[i];
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    minu_o.h[i] = gt16[i]  ? b_i.h[i] : a_i.h[i];
                    min_o.h[i]  = gts16[i] ? b_i.h[i] : a_i.h[i];
                    maxu_o.h[i] = gt16[i]  ? a_i.h[i] : b_i.h[i];
                    max_o.h[i]  = gts16[i] ? a_i.h[i] : b_i.h[i];
                end
            end
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    minu_o.w[i] = gt32[i]  ? b_i.w[i] : a_i.w[i];
                    min_o.w[i]  = gts32[i] ? b_i.w[i] : a_i.w[i];
                    maxu_o.w[i] = gt32[i]  ? a_i.w[i] : b_i.w[i];
                    max_o.w[i]  = gts32[i] ? a_i.w[i] : b_i.w[i];
                end
            end
        endcase
    end

endmodule

// ==== valu_lane_mul.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_lane_mul
    import valu_pkg::*;
(
    input  sew_e      sew_i,
    input  mul_sign_e sign_i,
    input  logic      high_i,
    input  vreg_u     a_i,
    input  vreg_u     b_i,
    output vreg_u     prod_o
);

    logic a_signed;
    logic b_signed;

    assign a_signed = (sign_i == mul_su) || (sign_i == mul_ss);
    assign b_signed = (sign_i == mul_ss);

    ////////////////////////////////////////
    // Double-width lane products
    ////////////////////////////////////////

    // Operands extended to twice the lane width, product taken modulo that width
    always_comb begin
        logic [15:0] ext_a8;
        logic [15:0] ext_b8;
        logic [15:0] full8;
        logic [31:0] ext_a16;
        logic [31:0] ext_b16;
        logic [31:0] full16;

        ext_a8  = '0;
        ext_b8  = '0;
        full8   = '0;
        ext_a16 = '0;
        ext_b16 = '0;
        full16  = '0;
        prod_o  = '0;

        unique case (sew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    ext_a8      = {{8{a_signed & a_i.b[i][7]}}, a_i.b[i]};
                    ext_b8      = {{8{b_signed & b_i.b[i][7]}}, b_i.b[i]};
                    full8       = ext_a8 * ext_b8;
                    prod_o.b[i] = high_i ? full8[15:8] : full8[7:0];
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    ext_a16     = {{16{a_signed & a_i.h[i][15]}}, a_i.h[i]};
                    ext_b16     = {{16{b_signed & b_i.h[i][15]}}, b_i.h[i]};
                    full16      = ext_a16 * ext_b16;
                    prod_o.h[i] = high_i ? full16[31:16] : full16[15:0];
                end
            end
            default: begin
                // 32-bit lanes go through the sequential multiplier
                prod_o = '0;
            end
        endcase
    end

endmodule

// ==== valu_seq_mul32.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_seq_mul32
    import valu_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start_i,
    input  mul_sign_e   sign_i,
    input  logic        high_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [31:0] prod_o
);

    localparam int STEPS = 32 / `VALU_MUL_STEP;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             launch;
    logic             last_step;
    logic             a_neg;
    logic             b_neg;
    logic [31:0]      a_mag;
    logic [31:0]      b_mag;
    logic [63:0]      mcand_q;
    logic [31:0]      mplier_q;
    logic [63:0]      acc_q;
    logic [63:0]      acc_next;
    logic             neg_q;
    logic             high_q;

    // Signed operands become magnitudes, sign restored at the end
    assign a_neg = ((sign_i == mul_su) || (sign_i == mul_ss)) && a_i[31];
    assign b_neg = (sign_i == mul_ss) && b_i[31];
    assign a_mag = a_neg ? -a_i : a_i;
    assign b_mag = b_neg ? -b_i : b_i;

    assign launch    = start_i && !busy_q;
    assign last_step = (cnt_q == CNT_W'(STEPS - 1));
    assign done_o    = busy_q && (cnt_q == CNT_W'(STEPS));
    assign busy_o    = busy_q || start_i;

    // One radix 2^STEP digit of the multiplier per cycle
    assign acc_next = acc_q + mcand_q * 64'(mplier_q[`VALU_MUL_STEP-1:0]);

    assign prod_o = high_q ? acc_q[63:32] : acc_q[31:0];

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (launch) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            if (done_o) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (launch) begin
            mcand_q  <= {32'd0, a_mag};
            mplier_q <= b_mag;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            high_q   <= high_i;
        end else if (busy_q && !done_o) begin
            mcand_q  <= mcand_q << `VALU_MUL_STEP;
            mplier_q <= mplier_q >> `VALU_MUL_STEP;
            // Sign applied with the final digit, kept until next launch
            acc_q    <= (last_step && neg_q) ? -acc_next : acc_next;
        end
    end

endmodule

// ==== valu_top.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module valu_top
    import valu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start_i,
    input  valu_op_e op_i,
    input  sew_e     sew_i,
    input  vreg_u    a_i,
    input  vreg_u    b_i,
    output logic     hold_o,
    output logic     result_valid_o,
    output vreg_u    result_o
);

    vreg_u     res_and, res_or, res_xor, res_sum;
    vreg_u     res_sll, res_srl, res_sra;
    vreg_u     res_min, res_minu, res_max, res_maxu;
    vreg_u     lane_prod, mul32_res, res_mul, result_next;
    mul_sign_e mul_sign;
    logic      mul_high;
    logic      is_mul;
    logic      mul32_req;
    logic      accept;

    logic [`VALU_LANES32-1:0]       mul_busy;
    logic [`VALU_LANES32-1:0]       mul_done;
    logic [`VALU_LANES32-1:0][31:0] mul32_word;

    assign res_and = a_i & b_i;
    assign res_or  = a_i | b_i;
    assign res_xor = a_i ^ b_i;

    valu_add_sub u_add_sub (.op_i(op_i), .sew_i(sew_i), .a_i(a_i), .b_i(b_i), .sum_o(res_sum));

    valu_shift u_shift (
        .sew_i(sew_i), .a_i(a_i), .b_i(b_i),
        .sll_o(res_sll), .srl_o(res_srl), .sra_o(res_sra)
    );

    valu_minmax u_minmax (
        .sew_i(sew_i), .a_i(a_i), .b_i(b_i),
        .min_o(res_min), .minu_o(res_minu), .max_o(res_max), .maxu_o(res_maxu)
    );

    ////////////////////////////////////////
    // Multiply routing
    ////////////////////////////////////////
    assign is_mul    = op_i inside {vmul, vmulh, vmulhu, vmulhsu};
    assign mul_high  = op_i inside {vmulh, vmulhu, vmulhsu};
    assign mul_sign  = (op_i == vmulh) ? mul_ss : (op_i == vmulhsu) ? mul_su : mul_uu;
    assign mul32_req = start_i && is_mul && (sew_i == EW32);

    valu_lane_mul u_lane_mul (
        .sew_i(sew_i), .sign_i(mul_sign), .high_i(mul_high),
        .a_i(a_i), .b_i(b_i), .prod_o(lane_prod)
    );

    for (genvar i = 0; i < `VALU_LANES32; i++) begin : g_mul32
        valu_seq_mul32 u_mul32 (
            .clk(clk), .reset_n(reset_n), .start_i(mul32_req),
            .sign_i(mul_sign), .high_i(mul_high), .a_i(a_i.w[i]), .b_i(b_i.w[i]),
            .busy_o(mul_busy[i]), .done_o(mul_done[i]), .prod_o(mul32_word[i])
        );
    end

    assign mul32_res = mul32_word;
    assign res_mul   = (sew_i == EW32) ? mul32_res : lane_prod;

    // Stall while any 32-bit lane is still working on this request
    assign hold_o = mul32_req && |(mul_busy & ~mul_done);
    assign accept = start_i && !hold_o;

    ////////////////////////////////////////
    // Result select and register
    ////////////////////////////////////////
    always_comb begin
        unique case (op_i)
            vand:                          result_next = res_and;
            vor:                           result_next = res_or;
            vxor:                          result_next = res_xor;
            vsll:                          result_next = res_sll;
            vsrl:                          result_next = res_srl;
            vsra:                          result_next = res_sra;
            vmin:                          result_next = res_min;
            vminu:                         result_next = res_minu;
            vmax:                          result_next = res_max;
            vmaxu:                         result_next = res_maxu;
            vmul, vmulh, vmulhu, vmulhsu:  result_next = res_mul;
            default:                       result_next = res_sum;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_o <= result_next;
        end
    end

endmodule

// ==== tb_valu_asserts.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module tb_valu_asserts
    import valu_pkg::*;
(
    input logic  clk,
    input logic  reset_n,
    input logic  start_i,
    input logic  hold_i,
    input logic  valid_i,
    input vreg_u result_i
);

    localparam int HOLD_CYCLES = 32 / `VALU_MUL_STEP + 1;

    logic accepted;

    assign accepted = start_i && !hold_i;

    // A 32-bit multiply holds one cycle per multiplier digit plus one
    hold_length: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(hold_i) |-> $past(hold_i, HOLD_CYCLES) && !$past(hold_i, HOLD_CYCLES + 1))
        else $error("hold_o did not last %0d cycles", HOLD_CYCLES);

    // One result pulse per acceptance, one cycle later
    valid_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
        accepted |=> valid_i) else $error("result_valid_o missing after acceptance");

    valid_only_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> $past(accepted)) else $error("result_valid_o without prior acceptance");

    result_known: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> !$isunknown(result_i)) else $error("result_o has unknown bits while valid");

endmodule

// ==== tb_valu.sv ====
`timescale 1ns/10ps
`include "valu_settings.svh"

module tb_valu;
    import valu_pkg::*;

    localparam int TIMEOUT = 64;
    localparam int TRIALS  = 20;

    logic        clk;
    logic        reset_n;
    logic        start;
    valu_op_e    op_in;
    sew_e        sew_in;
    vreg_u       a_in;
    vreg_u       b_in;
    logic        hold;
    logic        result_valid;
    vreg_u       result;
    logic [31:0] rng_state;

    valu_top UUT (
        .clk(clk), .reset_n(reset_n), .start_i(start), .op_i(op_in), .sew_i(sew_in),
        .a_i(a_in), .b_i(b_in), .hold_o(hold), .result_valid_o(result_valid),
        .result_o(result)
    );

    bind valu_top tb_valu_asserts u_asserts (
        .clk(clk), .reset_n(reset_n), .start_i(start_i), .hold_i(hold_o),
        .valid_i(result_valid_o), .result_i(result_o)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // One lane of width bits, operands zero-extended into 32 bits
    function automatic logic [31:0] lane_result(input valu_op_e op, input int width,
                                                input logic [31:0] x, input logic [31:0] y);
        logic [63:0] mask;
        logic [63:0] ux;
        logic [63:0] uy;
        logic [63:0] sx;
        logic [63:0] sy;
        logic [63:0] r;
        int          sh;
        mask = (64'd1 << width) - 64'd1;
        ux   = 64'(x) & mask;
        uy   = 64'(y) & mask;
        sx   = ux[width-1] ? (ux | ~mask) : ux;
        sy   = uy[width-1] ? (uy | ~mask) : uy;
        // Only log2(width) bits of the amount count
        sh   = int'(uy & 64'(width - 1));
        case (op)
            vand:    r = ux & uy;
            vor:     r = ux | uy;
            vxor:    r = ux ^ uy;
            vadd:    r = ux + uy;
            vsub:    r = ux - uy;
            vrsub:   r = uy - ux;
            vsll:    r = ux << sh;
            vsrl:    r = ux >> sh;
            vsra:    r = $signed(sx) >>> sh;
            vmin:    r = ($signed(sx) < $signed(sy)) ? ux : uy;
            vminu:   r = (ux < uy) ? ux : uy;
            vmax:    r = ($signed(sx) > $signed(sy)) ? ux : uy;
            vmaxu:   r = (ux > uy) ? ux : uy;
            vmul:    r = ux * uy;
            vmulh:   r = (sx * sy) >> width;
            vmulhu:  r = (ux * uy) >> width;
            default: r = (sx * uy) >> width;
        endcase
        return 32'(r & mask);
    endfunction

    function automatic vreg_u model(input valu_op_e op, input sew_e sew,
                                    input vreg_u a, input vreg_u b);
        vreg_u r;
        r = '0;
        case (sew)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    r.b[i] = 8'(lane_result(op, 8, 32'(a.b[i]), 32'(b.b[i])));
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    r.h[i] = 16'(lane_result(op, 16, 32'(a.h[i]), 32'(b.h[i])));
                end
            end
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    r.w[i] = lane_result(op, 32, a.w[i], b.w[i]);
                end
            end
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_vec(input string name, input vreg_u exp, input vreg_u act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Vector result mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TESTS FAILED");
        $fatal(1, "Wait expired");
    endtask

    // Present one request, follow the hold handshake, check the single result
    task automatic run_op(input string name, input valu_op_e op, input sew_e sew,
                          input vreg_u a, input vreg_u b);
        vreg_u exp;
        logic  is_mul32;
        int    waited;
        exp      = model(op, sew, a, b);
        is_mul32 = (sew == EW32) && (op inside {vmul, vmulh, vmulhu, vmulhsu});
        @(posedge clk);
        #1;
        start  = 1'b1;
        op_in  = op;
        sew_in = sew;
        a_in   = a;
        b_in   = b;
        @(negedge clk);
        check_bit({name, " hold"}, is_mul32, hold);
        check_bit({name, " valid before accept"}, 1'b0, result_valid);
        waited = 0;
        while (hold && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            check_bit({name, " valid during hold"}, 1'b0, result_valid);
        end
        if (hold) begin
            stop_on_timeout("hold_o falling");
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_bit({name, " valid"}, 1'b1, result_valid);
        check_vec(name, exp, result);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        vreg_u       a;
        vreg_u       b;
        valu_op_e    op;
        logic [31:0] r;
        clk       = 1'b0;
        reset_n   = 1'b0;
        start     = 1'b0;
        op_in     = vand;
        sew_in    = EW8;
        a_in      = '0;
        b_in      = '0;
        rng_state = 32'h1a3a;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Idle after reset
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_bit("idle hold", 1'b0, hold);
            check_bit("idle valid", 1'b0, result_valid);
        end

        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o <= 16; o++) begin
                op = valu_op_e'(o);
                for (int t = 0; t < TRIALS; t++) begin
                    a = {next_rand(), next_rand()};
                    b = {next_rand(), next_rand()};
                    r = next_rand();
                    // Some equal lanes for min and max
                    if (op inside {vmin, vminu, vmax, vmaxu}) begin
                        if (r[0]) b.w[0] = a.w[0];
                        if (r[1]) b.h[2] = a.h[2];
                        if (r[2]) b.b[7] = a.b[7];
                    end
                    run_op($sformatf("%s ew%0d trial %0d", op.name(), 8 << s, t),
                           op, sew_e'(s), a, b);
                end
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
valu_pkg.sv
valu_add_sub.sv
valu_shift.sv
valu_minmax.sv
valu_lane_mul.sv
valu_seq_mul32.sv
valu_top.sv
tb_valu_asserts.sv
tb_valu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_valu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
